/* dv/mult_array_input.txt */
# Three lines per row: en then A lanes 0-7 / B lanes 0-7 / expected P lanes 0-7, all hex
# P is A times sign-extended B kept to 40 bits, lanes 6 and 7 run on the Booth bank
# Corners: most negative operands, largest positive operands
1 800000 FFFFFF 000000 000003 7FFFFF 800000 800000 7FFFFF
8000 0001 7FFF FFFF 7FFF 7FFF 8000 8000
4000000000 FFFFFFFFFF 0000000000 FFFFFFFFFD 3FFF7F8001 C000800000 4000000000 C000008000
# Mixed signs
1 FFFFFE 000010 FFFFFF 000100 FFF000 123456 FFFFFE 800000
0003 FFF0 FFFF 0100 0010 0001 0003 FFFF
FFFFFFFFFA FFFFFFFF00 0000000001 0000010000 FFFFFF0000 0000123456 FFFFFFFFFA 0000800000
# All-ones B negates A
1 000001 000002 00FFFF 7FFFFF 800000 FFFFFF 7FFFFF 000000
FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF
FFFFFFFFFF FFFFFFFFFE FFFFFF0001 FFFF800001 0000800000 0000000001 FFFF800001 0000000000
# Zero operands
1 000000 800000 7FFFFF 000000 ABCDEF 000000 000000 800000
8000 0000 0000 FFFF 0000 1234 8000 0000
0000000000 0000000000 0000000000 0000000000 0000000000 0000000000 0000000000 0000000000
# Powers of two
1 000001 000004 000100 400000 FFFFF0 000080 400000 FFFF00
0002 0008 1000 4000 0100 FF80 4000 FF00
0000000002 0000000020 0000100000 1000000000 FFFFFFF000 FFFFFFC000 1000000000 0000010000
# Alternating B bits for the Booth digits
1 000001 000001 000002 FFFFFF 000001 000001 000001 FFFFFF
5555 AAAA 5555 5555 7FFF 8001 AAAA AAAA
0000005555 FFFFFFAAAA 000000AAAA FFFFFFAAAB 0000007FFF FFFFFF8001 FFFFFFAAAA 0000005556
# Enable low with three rows in flight
0 000001 000001 000001 000001 000001 000001 000001 000001
0001 0001 0001 0001 0001 0001 0001 0001
0000000001 0000000001 0000000001 0000000001 0000000001 0000000001 0000000001 0000000001
0 000001 000001 000001 000001 000001 000001 000001 000001
FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF
FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF FFFFFFFFFF
# Small signed values
1 000003 000007 FFFFF6 00000C 001000 FFFFFD 000007 FFFFF6
0005 FFF9 000A 000C 0010 FFFB FFF9 000A
000000000F FFFFFFFFCF FFFFFFFF9C 0000000090 0000010000 000000000F FFFFFFFFCF FFFFFFFF9C
1 010000 000FFF FFFF00 000200 020000 000011 000FFF 000200
0100 0011 0101 F000 FFFE 0011 0011 F000
0001000000 0000010FEF FFFFFEFF00 FFFFE00000 FFFFFC0000 0000000121 0000010FEF FFFFE00000
# Single idle row
0 7FFFFF 7FFFFF 7FFFFF 7FFFFF 7FFFFF 7FFFFF 7FFFFF 7FFFFF
7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF
3FFF7F8001 3FFF7F8001 3FFF7F8001 3FFF7F8001 3FFF7F8001 3FFF7F8001 3FFF7F8001 3FFF7F8001
# Wider A patterns
1 123456 123456 000001 FFFFFF 000010 000100 123456 123456
0010 FFFF 1234 1234 1234 FFFF FFFF 0010
0001234560 FFFFEDCBAA 0000001234 FFFFFFEDCC 0000012340 FFFFFFFF00 FFFFEDCBAA 0001234560
1 7FFFFF 800000 7FFFFF 800000 000003 FFFFFD 7FFFFF 800000
0002 0002 FFFE FFFE 8000 8000 FFFE 0002
0000FFFFFE FFFF000000 FFFF000002 0001000000 FFFFFE8000 0000018000 FFFF000002 FFFF000000
1 FFFFFF 000001 7FFFFF 800000 000002 FFFFFE FFFFFF 800000
8000 8000 0001 0001 4000 4000 8000 0001
0000008000 FFFFFF8000 00007FFFFF FFFF800000 0000008000 FFFFFF8000 0000008000 FFFF800000
# Idle row, then one more enabled row
0 000001 000001 000001 000001 000001 000001 000001 000001
0001 0001 0001 0001 0001 0001 0001 0001
0000000001 0000000001 0000000001 0000000001 0000000001 0000000001 0000000001 0000000001
1 000005 000009 FFFFFB 000005 FFFFFB 000064 FFFFFB 000064
0007 0009 0007 FFF9 FFF9 0064 0007 0064
0000000023 0000000051 FFFFFFFFDD FFFFFFFFDD 0000000023 0000002710 FFFFFFFFDD 0000002710

/* mult_array.f */
source/mult_array_pkg.sv
source/booth_mult_s24_s18.sv
source/mult_lut_bank.sv
source/mult_dsp_bank.sv
source/mult_array.sv
dv/mult_array_tb.sv

/* run_mult_array.sh */
#!/bin/sh
# Build and run the mult_array testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module mult_array_tb \
  -f mult_array.f -o sim_mult_array \
  && ./obj_dir/sim_mult_array | tee /dev/stderr | grep -qx "=== PASS ===" \
  && echo "mult_array simulation passed" \
  || { echo "mult_array simulation failed"; exit 1; }

/* dv/mult_array_tb.sv */
module mult_array_tb;
  timeunit 1ns;
  timeprecision 1ps;

  ////////////////////////////////////////
  // Run length
  ////////////////////////////////////////

  localparam int reset_cycles = 10;
  localparam int n_random = 200;

  // Flat vector widths at the DUT ports
  localparam int vec_a_w = mult_array_pkg::lanes * mult_array_pkg::a_w;
  localparam int vec_b_w = mult_array_pkg::lanes * mult_array_pkg::b_w;
  localparam int vec_p_w = mult_array_pkg::lanes * mult_array_pkg::p_w;

  // One stimulus row with its expected products
  typedef struct packed {
    logic               en;
    logic [vec_a_w-1:0] a;
    logic [vec_b_w-1:0] b;
    logic [vec_p_w-1:0] p;
  } stim_row_t;

  logic               clk;
  logic               rst;
  logic               en;
  logic [vec_a_w-1:0] vector_A;
  logic [vec_b_w-1:0] vector_B;
  logic [vec_p_w-1:0] vector_P;

  stim_row_t          rows[$];
  // Model of the three pipeline stages with the output stage at the front
  logic [vec_p_w-1:0] expect_q[$];

  int error_count = 0;
  int check_count = 0;
  int cycle_count = 0;
  int cycle_limit = 0;
  bit load_ok;

  mult_array u_mult_array (
    .clk      (clk),
    .rst      (rst),
    .en       (en),
    .vector_A (vector_A),
    .vector_B (vector_B),
    .vector_P (vector_P)
  );

  // 10 ns clock
  always #5 clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout: run still going after %0d clock cycles", cycle_count);
      $display("=== FAIL ===");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Checking
  ////////////////////////////////////////

  task automatic check_value(input int lane, input logic [mult_array_pkg::p_w-1:0] actual,
                             input logic [mult_array_pkg::p_w-1:0] expected, input string what);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Error at %0t: lane %0d %s got %h expected %h", $time, lane, what, actual,
               expected);
    end
  endtask

  // All lanes against the model's output stage
  task automatic compare_outputs();
    for (int i = 0; i < mult_array_pkg::lanes; i++) begin
      check_value(i, vector_P[i*mult_array_pkg::p_w +: mult_array_pkg::p_w],
                  expect_q[0][i*mult_array_pkg::p_w +: mult_array_pkg::p_w], "product");
    end
  endtask

  // Signed A times sign-extended B with the low 40 bits kept
  function automatic logic [mult_array_pkg::p_w-1:0] expected_product(
    input logic [mult_array_pkg::a_w-1:0] a, input logic [mult_array_pkg::b_w-1:0] b);
    logic signed [mult_array_pkg::full_p_w-1:0] a_x;
    logic signed [mult_array_pkg::full_p_w-1:0] b_x;
    logic signed [mult_array_pkg::full_p_w-1:0] full;
    a_x = {{(mult_array_pkg::full_p_w - mult_array_pkg::a_w){a[mult_array_pkg::a_w-1]}}, a};
    b_x = {{(mult_array_pkg::full_p_w - mult_array_pkg::b_w){b[mult_array_pkg::b_w-1]}}, b};
    full = a_x * b_x;
    return full[mult_array_pkg::p_w-1:0];
  endfunction

  ////////////////////////////////////////
  // Stimulus file
  ////////////////////////////////////////

  // Next line that is neither blank nor a comment
  task automatic read_data_line(input int fd, output string line, output bit found);
    string raw;
    int    code;
    bit    done;
    found = 0;
    done = 0;
    while (!found && !done) begin
      code = $fgets(raw, fd);
      if (code == 0) begin
        done = 1;
      end else if (raw.len() > 0 && raw.getc(0) != "#" && raw.getc(0) != "\n") begin
        line = raw;
        found = 1;
      end
    end
  endtask

  // Three lines per row with en and A first, then B, then expected P
  task automatic load_stimulus(output bit ok);
    int            fd;
    string         l_a;
    string         l_b;
    string         l_p;
    bit            f_a;
    bit            f_b;
    bit            f_p;
    int            n_a;
    int            n_b;
    int            n_p;
    bit            more;
    logic [39:0]   va[9];
    logic [39:0]   vb[8];
    logic [39:0]   vp[8];
    stim_row_t     row;
    ok = 1;
    fd = $fopen("dv/mult_array_input.txt", "r");
    if (fd == 0) begin
      ok = 0;
    end else begin
      more = 1;
      while (more) begin
        read_data_line(fd, l_a, f_a);
        if (!f_a) begin
          more = 0;
        end else begin
          read_data_line(fd, l_b, f_b);
          read_data_line(fd, l_p, f_p);
          n_a = $sscanf(l_a, "%h %h %h %h %h %h %h %h %h", va[0], va[1], va[2], va[3],
                        va[4], va[5], va[6], va[7], va[8]);
          n_b = $sscanf(l_b, "%h %h %h %h %h %h %h %h", vb[0], vb[1], vb[2], vb[3],
                        vb[4], vb[5], vb[6], vb[7]);
          n_p = $sscanf(l_p, "%h %h %h %h %h %h %h %h", vp[0], vp[1], vp[2], vp[3],
                        vp[4], vp[5], vp[6], vp[7]);
          if (!f_b || !f_p || n_a != 9 || n_b != 8 || n_p != 8) begin
            ok = 0;
            more = 0;
          end else begin
            row.en = va[0][0];
            for (int i = 0; i < mult_array_pkg::lanes; i++) begin
              row.a[i*mult_array_pkg::a_w +: mult_array_pkg::a_w] = va[i+1][23:0];
              row.b[i*mult_array_pkg::b_w +: mult_array_pkg::b_w] = vb[i][15:0];
              row.p[i*mult_array_pkg::p_w +: mult_array_pkg::p_w] = vp[i];
            end
            rows.push_back(row);
          end
        end
      end
      $fclose(fd);
      if (rows.size() == 0) begin
        ok = 0;
      end
    end
  endtask

  ////////////////////////////////////////
  // Driving
  ////////////////////////////////////////

  // Reset must win over an active enable with nonzero operands
  task automatic apply_reset();
    rst = 1'b1;
    en = 1'b1;
    vector_A = '1;
    vector_B = '1;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    en = 1'b0;
    vector_A = '0;
    vector_B = '0;
  endtask

  // Called on a falling edge and returns on the next one
  task automatic apply_vector(input stim_row_t row);
    compare_outputs();
    en = row.en;
    vector_A = row.a;
    vector_B = row.b;
    // Only an enabled edge moves the pipeline
    if (row.en) begin
      expect_q.delete(0);
      expect_q.push_back(row.p);
    end
    @(negedge clk);
    // An idle edge leaves the output stage where the model holds it
    if (!row.en) begin
      for (int i = 0; i < mult_array_pkg::lanes; i++) begin
        check_value(i, vector_P[i*mult_array_pkg::p_w +: mult_array_pkg::p_w],
                    expect_q[0][i*mult_array_pkg::p_w +: mult_array_pkg::p_w], "held output");
      end
    end
  endtask

  // Back-to-back random operands with three vectors in flight
  task automatic run_random();
    stim_row_t   row;
    logic [31:0] rnd_a;
    logic [31:0] rnd_b;
    row.en = 1'b1;
    for (int n = 0; n < n_random; n++) begin
      for (int i = 0; i < mult_array_pkg::lanes; i++) begin
        rnd_a = $urandom();
        rnd_b = $urandom();
        row.a[i*mult_array_pkg::a_w +: mult_array_pkg::a_w] = rnd_a[mult_array_pkg::a_w-1:0];
        row.b[i*mult_array_pkg::b_w +: mult_array_pkg::b_w] = rnd_b[mult_array_pkg::b_w-1:0];
        row.p[i*mult_array_pkg::p_w +: mult_array_pkg::p_w] =
          expected_product(rnd_a[mult_array_pkg::a_w-1:0], rnd_b[mult_array_pkg::b_w-1:0]);
      end
      apply_vector(row);
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    stim_row_t flush_row;
    void'($urandom(32'h191632be));
    clk = 1'b0;
    rst = 1'b1;
    en = 1'b0;
    vector_A = '0;
    vector_B = '0;
    load_stimulus(load_ok);
    if (!load_ok) begin
      $display("Stimulus file dv/mult_array_input.txt is missing or malformed");
      $display("=== FAIL ===");
      $finish;
    end else begin
      cycle_limit = 2 * (rows.size() + n_random + reset_cycles + mult_array_pkg::mult_latency);
      apply_reset();
      // Outputs must still be zero one idle edge after reset
      @(negedge clk);
      for (int i = 0; i < mult_array_pkg::lanes; i++) begin
        check_value(i, vector_P[i*mult_array_pkg::p_w +: mult_array_pkg::p_w], '0,
                    "after reset");
      end
      // Stages hold zero until the first enabled edge
      repeat (mult_array_pkg::mult_latency) expect_q.push_back('0);
      foreach (rows[r]) begin
        apply_vector(rows[r]);
      end
      run_random();
      // Drain the pipeline with zero operands
      flush_row = '0;
      flush_row.en = 1'b1;
      repeat (mult_array_pkg::mult_latency) apply_vector(flush_row);
      compare_outputs();
      $display("Checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
        $display("=== PASS ===");
      end else begin
        $display("=== FAIL ===");
      end
      $finish;
    end
  end

endmodule

/* source/mult_array.sv */
module mult_array (
  input  logic                                              clk,
  input  logic                                              rst,
  input  logic                                              en,
  input  logic [mult_array_pkg::lanes*mult_array_pkg::a_w-1:0] vector_A,
  input  logic [mult_array_pkg::lanes*mult_array_pkg::b_w-1:0] vector_B,
  output logic [mult_array_pkg::lanes*mult_array_pkg::p_w-1:0] vector_P
);

  ////////////////////////////////////////
  // Lane operands and products per bank
  ////////////////////////////////////////

  mult_array_pkg::lane_operands_t dsp_ops   [mult_array_pkg::dsp_lanes];
  mult_array_pkg::lane_operands_t lut_ops   [mult_array_pkg::lut_lanes];
  mult_array_pkg::lane_product_t  dsp_prods [mult_array_pkg::dsp_lanes];
  mult_array_pkg::lane_product_t  lut_prods [mult_array_pkg::lut_lanes];

  // Lane i takes slice i of each vector, low lanes on the DSP bank
  for (genvar i = 0; i < mult_array_pkg::lanes; i++) begin : g_lane
    if (i < mult_array_pkg::dsp_lanes) begin : g_dsp
      assign dsp_ops[i] = '{
        a: vector_A[i*mult_array_pkg::a_w +: mult_array_pkg::a_w],
        b: vector_B[i*mult_array_pkg::b_w +: mult_array_pkg::b_w]
      };
      // Keep the low 40 bits of the 42-bit product
      assign vector_P[i*mult_array_pkg::p_w +: mult_array_pkg::p_w] =
        dsp_prods[i][mult_array_pkg::p_w-1:0];
    end else begin : g_lut
      assign lut_ops[i-mult_array_pkg::dsp_lanes] = '{
        a: vector_A[i*mult_array_pkg::a_w +: mult_array_pkg::a_w],
        b: vector_B[i*mult_array_pkg::b_w +: mult_array_pkg::b_w]
      };
      assign vector_P[i*mult_array_pkg::p_w +: mult_array_pkg::p_w] =
        lut_prods[i-mult_array_pkg::dsp_lanes][mult_array_pkg::p_w-1:0];
    end
  end

  ////////////////////////////////////////
  // Multiplier banks
  ////////////////////////////////////////

  // Operator-based lanes 0 to 5
  mult_dsp_bank #(
    .n_lanes (mult_array_pkg::dsp_lanes)
  ) u_mult_dsp_bank (
    .clk      (clk),
    .rst      (rst),
    .en       (en),
    .operands (dsp_ops),
    .products (dsp_prods)
  );

  // Booth lanes 6 and 7, same three-stage latency
  mult_lut_bank #(
    .n_lanes (mult_array_pkg::lut_lanes)
  ) u_mult_lut_bank (
    .clk      (clk),
    .rst      (rst),
    .en       (en),
    .operands (lut_ops),
    .products (lut_prods)
  );

endmodule

/* source/mult_dsp_bank.sv */
module mult_dsp_bank #(
  parameter int n_lanes = mult_array_pkg::dsp_lanes
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           en,
  input  mult_array_pkg::lane_operands_t operands [n_lanes],
  output mult_array_pkg::lane_product_t  products [n_lanes]
);

  ////////////////////////////////////////
  // Per-lane DSP-style pipeline
  ////////////////////////////////////////

  for (genvar i = 0; i < n_lanes; i++) begin : g_lane

    // Sign-extended B as fed to the multiplier
    logic signed [mult_array_pkg::ext_b_w-1:0] b_ext;

    // Input registers, like the A and B registers of a DSP slice
    logic signed [mult_array_pkg::a_w-1:0]     a_q;
    logic signed [mult_array_pkg::ext_b_w-1:0] b_q;

    // Middle register holding the raw product
    mult_array_pkg::lane_product_t m_q;

    // Output register
    mult_array_pkg::lane_product_t p_q;

    assign b_ext = {
      {(mult_array_pkg::ext_b_w - mult_array_pkg::b_w){operands[i].b[mult_array_pkg::b_w-1]}},
      operands[i].b
    };

    // Stage 1 samples the operands
    always_ff @(posedge clk) begin
      if (rst) begin
        a_q <= '0;
        b_q <= '0;
      end else if (en) begin
        a_q <= operands[i].a;
        b_q <= b_ext;
      end
    end

    // Stage 2 multiplies, both operands signed so the product is signed
    always_ff @(posedge clk) begin
      if (rst) begin
        m_q <= '0;
      end else if (en) begin
        m_q <= a_q * b_q;
      end
    end

    // Stage 3 retimes the product
    always_ff @(posedge clk) begin
      if (rst) begin
        p_q <= '0;
      end else if (en) begin
        p_q <= m_q;
      end
    end

    assign products[i] = p_q;

  end

endmodule

/* source/mult_lut_bank.sv */
module mult_lut_bank #(
  parameter int n_lanes = mult_array_pkg::lut_lanes
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           en,
  input  mult_array_pkg::lane_operands_t operands [n_lanes],
  output mult_array_pkg::lane_product_t  products [n_lanes]
);

  ////////////////////////////////////////
  // One Booth multiplier per lane
  ////////////////////////////////////////

  for (genvar i = 0; i < n_lanes; i++) begin : g_lane

    // B widened to the multiplier input width
    logic signed [mult_array_pkg::ext_b_w-1:0] b_ext;

    // Replicate the sign bit of the 16-bit B
    assign b_ext = {
      {(mult_array_pkg::ext_b_w - mult_array_pkg::b_w){operands[i].b[mult_array_pkg::b_w-1]}},
      operands[i].b
    };

    // Three-stage pipeline, same latency as the DSP bank
    booth_mult_s24_s18 u_booth_mult (
      .clk (clk),
      .rst (rst),
      .en  (en),
      .a   (operands[i].a),
      .b   (b_ext),
      .p   (products[i])
    );

  end

endmodule

/* source/booth_mult_s24_s18.sv */
module booth_mult_s24_s18 (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   en,
  input  logic signed [mult_array_pkg::a_w-1:0]     a,
  input  logic signed [mult_array_pkg::ext_b_w-1:0] b,
  output mult_array_pkg::lane_product_t           p
);

  ////////////////////////////////////////
  // Stage 1 operand registers
  ////////////////////////////////////////

  logic signed [mult_array_pkg::a_w-1:0]     a_q;
  logic signed [mult_array_pkg::ext_b_w-1:0] b_q;

  // Both operands advance together on an enabled edge
  always_ff @(posedge clk) begin
    if (rst) begin
      a_q <= '0;
      b_q <= '0;
    end else if (en) begin
      a_q <= a;
      b_q <= b;
    end
  end

  ////////////////////////////////////////
  // Stage 2 Booth recode and half sums
  ////////////////////////////////////////

  // Half sums of the partial products, before and after the register
  logic signed [mult_array_pkg::full_p_w-1:0] sum_lo_d;
  logic signed [mult_array_pkg::full_p_w-1:0] sum_hi_d;
  logic signed [mult_array_pkg::full_p_w-1:0] sum_lo_q;
  logic signed [mult_array_pkg::full_p_w-1:0] sum_hi_q;

  // B with an implied zero below bit 0 for the first digit
  logic [mult_array_pkg::ext_b_w:0] b_pad;

  assign b_pad = {b_q, 1'b0};

  // Radix-4 recode gives ext_b_w/2 digits in the range -2 to +2
  always_comb begin : booth_recode
    logic [2:0]                                 triplet;
    logic signed [mult_array_pkg::full_p_w-1:0] a_ext;
    logic signed [mult_array_pkg::full_p_w-1:0] pp;

    sum_lo_d = '0;
    sum_hi_d = '0;
    // Signed A widened to the product width
    a_ext = a_q;

    for (int i = 0; i < mult_array_pkg::ext_b_w / 2; i++) begin
      // Overlapping bit triplet b[2i+1], b[2i], b[2i-1]
      triplet = b_pad[2*i +: 3];

      // Select the multiple of A for this digit
      case (triplet)
        3'b001, 3'b010: pp = a_ext;
        3'b011:         pp = a_ext <<< 1;
        3'b100:         pp = -(a_ext <<< 1);
        3'b101, 3'b110: pp = -a_ext;
        default:        pp = '0;
      endcase

      // Weight of digit i is 4 to the power i
      pp = pp <<< (2 * i);

      // Lower digits go to one adder tree, upper digits to the other
      if (2 * i < mult_array_pkg::ext_b_w / 2) begin
        sum_lo_d = sum_lo_d + pp;
      end else begin
        sum_hi_d = sum_hi_d + pp;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      sum_lo_q <= '0;
      sum_hi_q <= '0;
    end else if (en) begin
      sum_lo_q <= sum_lo_d;
      sum_hi_q <= sum_hi_d;
    end
  end

  ////////////////////////////////////////
  // Stage 3 final add
  ////////////////////////////////////////

  // Sum of both halves is the exact 42-bit product
  always_ff @(posedge clk) begin
    if (rst) begin
      p <= '0;
    end else if (en) begin
      p <= sum_lo_q + sum_hi_q;
    end
  end

endmodule

/* source/mult_array_pkg.sv */
package mult_array_pkg;

  ////////////////////////////////////////
  // Array geometry
  ////////////////////////////////////////

  // Total lane count
  localparam int lanes = 8;

  // Lanes 0 to 5 run on the DSP-style bank
  localparam int dsp_lanes = 6;

  // Remaining lanes run on the Booth bank
  localparam int lut_lanes = lanes - dsp_lanes;

  ////////////////////////////////////////
  // Operand and product widths
  ////////////////////////////////////////

  // Signed operand widths at the array ports
  localparam int a_w = 24;
  localparam int b_w = 16;

  // B after sign extension inside both banks
  localparam int ext_b_w = 18;

  // Full internal product, a_w plus ext_b_w
  localparam int full_p_w = a_w + ext_b_w;

  // Product width kept at the top level
  localparam int p_w = 40;

  // Enabled clock edges from operand sample to product
  localparam int mult_latency = 3;

  // One lane's operand pair, A in the upper bits
  typedef struct packed {
    logic signed [a_w-1:0] a;
    logic signed [b_w-1:0] b;
  } lane_operands_t;

  // Full signed product of one lane
  typedef logic signed [full_p_w-1:0] lane_product_t;

endpackage
